// File: bench/spi_master_properties.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master_properties (
  input wire                 clk,
  input wire                 rst_n,
  input spi_pkg::spi_state_t state,
  input wire                 cs,
  input wire                 sclk,
  input wire                 mosi,
  input wire                 read_vld,
  input wire                 read_rdy
);

  import spi_pkg::*;

  int unsigned fail_cnt = 0;

  idle_pins: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_IDLE) |-> (cs && !sclk))
  else
  begin
    fail_cnt++;
    $error("cs low or sclk high while the master is idle");
  end

  // sclk only runs inside a frame.
  sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk)
  else
  begin
    fail_cnt++;
    $error("sclk high while cs is high");
  end

  mosi_steady: assert property (@(posedge clk) disable iff (!rst_n)
    sclk |-> $stable(mosi))
  else
  begin
    fail_cnt++;
    $error("mosi changed while sclk was high");
  end

  // a byte that the read FIFO has not taken stays offered in finish.
  read_in_finish: assert property (@(posedge clk) disable iff (!rst_n)
    (read_vld && !read_rdy) |=> (read_vld && (state == ST_FINISH)))
  else
  begin
    fail_cnt++;
    $error("read_vld dropped or the master left finish before the read FIFO took the byte");
  end

endmodule

bind spi_master spi_master_properties u_props (
  .clk(clk), .rst_n(rst_n), .state(state), .cs(cs),
  .sclk(sclk), .mosi(mosi), .read_vld(read_vld), .read_rdy(read_rdy)
);

`default_nettype wire

// File: bench/tb_spi_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_ctrl;

  import spi_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;

  logic [31:0] rng;
  logic [7:0]  exp_regs [8];
  logic [7:0]  exp_q [$];
  logic [7:0]  slave_regs [8];
  logic [11:0] frame_bits;
  int          frame_edges;
  logic        frame_wr;
  logic [2:0]  frame_addr;
  logic        cs_q;
  logic        sclk_q;

  spi_ctrl_top #(.SCLK_DIV(4), .FIFO_DEPTH(4)) UUT (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      fail_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                         name, expected, actual));
  endtask

  task automatic drive_transfer(input logic wr, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    for (n = 0; n < 10 && !pready; n++)
      @(negedge clk);
    if (!pready)
      fail_run("the APB slave never raised pready");
    rdata = prdata; // pready is high until the next rising edge.
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    drive_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    drive_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  // polls one STATUS bit until it reaches the wanted level.
  task automatic wait_status(input int bit_idx, input logic value, input string what);
    logic [31:0] d;
    logic        err;
    for (int n = 0; n < 300; n++)
    begin
      apb_read(REG_STATUS, d, err);
      if (d[bit_idx] == value)
        return;
    end
    fail_run($sformatf("timed out waiting for %s", what));
  endtask

  task automatic wait_stall();
    for (int n = 0; n < 2000; n++)
    begin
      @(negedge clk);
      if (UUT.read_vld && !UUT.read_rdy)
        return;
    end
    fail_run("the master never stalled on a full read FIFO");
  endtask

  task automatic issue_cmd(input logic wr, input logic [2:0] addr, input logic [7:0] data);
    logic err;
    apb_write(REG_CMD, {20'd0, wr, addr, data}, err);
    check_value("command push", 0, err);
    if (wr)
      exp_regs[addr] = data;
    else
      exp_q.push_back(exp_regs[addr]); // value the slave holds when this read runs.
  endtask

  task automatic pop_and_compare(input string name);
    logic [31:0] d;
    logic        err;
    wait_status(1, 1'b1, "read data");
    apb_read(REG_RXDATA, d, err);
    check_value({name, " pop error"}, 0, err);
    check_value(name, {24'd0, exp_q.pop_front()}, d);
  endtask

  // the spi slave model samples the pins on the falling clk edge.
  always @(negedge clk)
  begin
    if (!cs && cs_q)
    begin
      frame_edges = 0;
      frame_bits  = '0;
      frame_wr    = 1'b1;
    end
    if (!cs && sclk && !sclk_q)
    begin
      frame_bits  = {frame_bits[10:0], mosi};
      frame_edges = frame_edges + 1;
      if (frame_edges == 4)
      begin
        frame_wr   = frame_bits[3];
        frame_addr = frame_bits[2:0];
      end
    end
    if (!cs && !sclk && sclk_q && !frame_wr && frame_edges >= 4 && frame_edges < 12)
      miso = slave_regs[frame_addr][11 - frame_edges];
    if (cs && !cs_q && rst_n)
    begin
      if (frame_edges != 12)
        fail_run($sformatf("spi frame had %0d sclk rising edges instead of 12",
                           frame_edges));
      else if (frame_bits[11])
        slave_regs[frame_bits[10:8]] = frame_bits[7:0];
    end
    cs_q   = cs;
    sclk_q = sclk;
  end

  always @(negedge clk)
  begin
    if (UUT.u_master.u_props.fail_cnt != 0)
      fail_run("an assertion on the spi_master pins failed");
  end

  initial
  begin
    logic [31:0] d;
    logic        err;
    logic [31:0] r;
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 4'd0;
    pwdata      = 32'd0;
    miso        = 1'b0;
    rng         = 32'h709e;
    cs_q        = 1'b1;
    sclk_q      = 1'b0;
    frame_edges = 0;
    frame_bits  = '0;
    frame_wr    = 1'b1;
    frame_addr  = 3'd0;
    for (int i = 0; i < 8; i++)
    begin
      exp_regs[i]   = 8'd0;
      slave_regs[i] = 8'd0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_value("reset cs", 1, cs);
    check_value("reset sclk", 0, sclk);
    check_value("reset mosi", 0, mosi);
    check_value("reset pready", 0, pready);
    check_value("reset pslverr", 0, pslverr);
    check_value("reset read_vld", 0, UUT.read_vld);
    apb_read(REG_STATUS, d, err);
    check_value("reset status", 0, d);

    // the first eight writes cover every register.
    for (int i = 0; i < 12; i++)
    begin
      r = xorshift32();
      issue_cmd(1'b1, (i < 8) ? 3'(i) : r[10:8], r[7:0]);
      wait_status(2, 1'b0, "idle after a write");
    end
    for (int i = 0; i < 8; i++)
    begin
      issue_cmd(1'b0, 3'(i), 8'd0);
      pop_and_compare("register readback");
    end

    for (int n = 0; n < 200; n++)
    begin
      r = xorshift32();
      while (exp_q.size() >= 3)
        pop_and_compare("random mix");
      wait_status(0, 1'b0, "room in the command FIFO");
      issue_cmd(r[11], r[10:8], r[7:0]);
      if (r[12] && exp_q.size() > 0)
      begin
        apb_read(REG_STATUS, d, err);
        if (d[1])
          pop_and_compare("random mix");
      end
    end
    wait_status(2, 1'b0, "idle after the random mix");
    while (exp_q.size() > 0)
      pop_and_compare("random mix");

    apb_read(REG_RXDATA, d, err);
    check_value("empty rxdata error", 1, err);
    check_value("empty rxdata value", 0, d);
    apb_read(4'hC, d, err);
    check_value("unmapped read error", 1, err);
    apb_write(4'h2, 32'd0, err);
    check_value("unmapped write error", 1, err);
    apb_write(REG_STATUS, 32'd0, err);
    check_value("status write error", 1, err);

    // five reads against a four entry read FIFO.
    for (int i = 0; i < 5; i++)
      issue_cmd(1'b0, 3'(i), 8'd0);
    wait_stall();
    apb_read(REG_STATUS, d, err);
    check_value("stall status", 32'h6, d);
    for (int i = 0; i < 4; i++)
    begin
      r = xorshift32();
      issue_cmd(1'b1, r[10:8], r[7:0]);
    end
    apb_read(REG_STATUS, d, err);
    check_value("full status", 32'h7, d);
    r = xorshift32();
    apb_write(REG_CMD, {20'd0, 1'b1, r[10:0]}, err);
    check_value("overflow error", 1, err);
    while (exp_q.size() > 0)
      pop_and_compare("stalled reads");
    wait_status(2, 1'b0, "idle after back-pressure");

    if (UUT.u_master.u_props.fail_cnt == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
      fail_run("an assertion on the spi_master pins failed");
  end

endmodule

`default_nettype wire

// File: project.f
verilog/spi_pkg.sv
verilog/spi_sync_fifo.sv
verilog/spi_sclk_gen.sv
verilog/spi_master.sv
verilog/spi_apb_regs.sv
verilog/spi_ctrl_top.sv
bench/spi_master_properties.sv
bench/tb_spi_ctrl.sv

// File: verilog/spi_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module spi_apb_regs (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  wire [3:0]         paddr,
  input  wire [31:0]        pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              cmd_push_vld,
  output spi_pkg::spi_cmd_t cmd_push_data,
  input  wire               cmd_push_rdy,
  input  wire               cmd_full,
  input  wire               cmd_not_empty,
  input  wire               rd_pop_vld,
  output logic              rd_pop_rdy,
  input  spi_pkg::spi_rd_t  rd_pop_data,
  input  wire               master_busy
);

  import spi_pkg::*;

  logic wait_q;
  logic hit_cmd;
  logic hit_status;
  logic hit_rxdata;
  logic bad_access;
  logic [31:0] status_word;

  // first access cycle is the wait state, pready comes in the second.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wait_q <= 1'b0;
    else
      wait_q <= psel && penable && !wait_q;
  end

  assign pready = psel && penable && wait_q;

  assign hit_cmd    = (paddr == REG_CMD);
  assign hit_status = (paddr == REG_STATUS);
  assign hit_rxdata = (paddr == REG_RXDATA);

  // unmapped offsets and writes to the read-only registers.
  assign bad_access = !(hit_cmd || hit_status || hit_rxdata) ||
                      (pwrite && (hit_status || hit_rxdata));

  assign cmd_push_vld  = pready && pwrite && hit_cmd;
  assign cmd_push_data = pwdata[CMD_WIDTH-1:0];
  assign rd_pop_rdy    = pready && !pwrite && hit_rxdata;

  assign status_word = {29'd0, master_busy | cmd_not_empty, rd_pop_vld, cmd_full};

  always_comb
  begin
    prdata = 32'd0;
    if (!pwrite)
    begin
      if (hit_status)
        prdata = status_word;
      else if (hit_rxdata && rd_pop_vld)
        prdata = {24'd0, rd_pop_data};
    end
  end

  always_comb
  begin
    pslverr = 1'b0;
    if (pready)
    begin
      if (bad_access)
        pslverr = 1'b1;
      else if (pwrite && hit_cmd && !cmd_push_rdy)
        pslverr = 1'b1; // command is dropped.
      else if (!pwrite && hit_rxdata && !rd_pop_vld)
        pslverr = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_ctrl_top #(
  parameter int SCLK_DIV   = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [3:0]  paddr,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        sclk,
  output logic        cs,
  output logic        mosi,
  input  wire         miso
);

  import spi_pkg::*;

  spi_cmd_t cmd_push_data;
  spi_cmd_t cmd_in;
  spi_rd_t  read_data;
  spi_rd_t  rd_pop_data;
  logic     cmd_push_vld;
  logic     cmd_push_rdy;
  logic     cmd_full;
  logic     cmd_not_empty;
  logic     cmd_vld;
  logic     cmd_rdy;
  logic     read_vld;
  logic     read_rdy;
  logic     rd_pop_vld;
  logic     rd_pop_rdy;
  logic     master_busy;

  spi_apb_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .cmd_push_vld (cmd_push_vld),
    .cmd_push_data(cmd_push_data),
    .cmd_push_rdy (cmd_push_rdy),
    .cmd_full     (cmd_full),
    .cmd_not_empty(cmd_not_empty),
    .rd_pop_vld   (rd_pop_vld),
    .rd_pop_rdy   (rd_pop_rdy),
    .rd_pop_data  (rd_pop_data),
    .master_busy  (master_busy)
  );

  spi_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(spi_cmd_t)) u_cmd_fifo (
    .clk(clk), .rst_n(rst_n),
    .push_vld(cmd_push_vld), .push_data(cmd_push_data), .push_rdy(cmd_push_rdy),
    .pop_vld(cmd_vld), .pop_rdy(cmd_rdy), .pop_data(cmd_in),
    .full(cmd_full), .not_empty(cmd_not_empty)
  );

  // read fifo flags are seen by the regs through rd_pop_vld only.
  spi_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(spi_rd_t)) u_rd_fifo (
    .clk(clk), .rst_n(rst_n),
    .push_vld(read_vld), .push_data(read_data), .push_rdy(read_rdy),
    .pop_vld(rd_pop_vld), .pop_rdy(rd_pop_rdy), .pop_data(rd_pop_data),
    .full(), .not_empty()
  );

  spi_master #(.SCLK_DIV(SCLK_DIV)) u_master (
    .clk(clk), .rst_n(rst_n),
    .cmd_in(cmd_in), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy),
    .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso),
    .read_vld(read_vld), .read_rdy(read_rdy), .read_data(read_data),
    .busy(master_busy)
  );

endmodule

`default_nettype wire

// File: verilog/spi_master.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master #(
  parameter int SCLK_DIV = 4
) (
  input  wire               clk,
  input  wire               rst_n,
  input  spi_pkg::spi_cmd_t cmd_in,
  input  wire               cmd_vld,
  output logic              cmd_rdy,
  output logic              sclk,
  output logic              cs,
  output logic              mosi,
  input  wire               miso,
  output logic              read_vld,
  input  wire               read_rdy,
  output spi_pkg::spi_rd_t  read_data,
  output logic              busy
);

  import spi_pkg::*;

  localparam int BW = $clog2(CMD_WIDTH);
  localparam int WCW = $clog2(2 * SCLK_DIV + 1);
  localparam logic [WCW-1:0] LEAD_LAST = WCW'(2 * SCLK_DIV - 1);
  localparam logic [WCW-1:0] HOLD_LAST = WCW'(SCLK_DIV - 1);
  localparam logic [WCW-1:0] HOLD_DONE = WCW'(SCLK_DIV);
  localparam logic [WCW-1:0] CNT_MAX   = WCW'(2 * SCLK_DIV);

  spi_state_t     state;
  spi_state_t     state_nxt;
  spi_cmd_t       cmd_buf;
  spi_rd_t        rx_shift;
  logic           wr_flag;
  logic [BW-1:0]  bit_cnt;
  logic [WCW-1:0] wait_cnt;
  logic           sclk_en;
  logic           rise_stb;
  logic           fall_stb;
  logic           tx_phase;
  logic           hold_over;

  assign cmd_rdy   = (state == ST_IDLE);
  assign busy      = (state != ST_IDLE);
  assign tx_phase  = (state == ST_JUDGE) || (state == ST_W_DATA) || (state == ST_R_ADDR);
  assign sclk_en   = (state == ST_W_DATA) || (state == ST_R_ADDR) || (state == ST_R_DATA);
  assign hold_over = (wait_cnt >= HOLD_LAST);

  // cs covers the lead-in, the data bits and the first part of finish.
  assign cs = ~(tx_phase || (state == ST_R_DATA) ||
                ((state == ST_FINISH) && (wait_cnt < HOLD_DONE)));
  assign mosi      = tx_phase & cmd_buf[CMD_WIDTH-1];
  assign read_vld  = (state == ST_FINISH) && !wr_flag && hold_over;
  assign read_data = rx_shift;

  spi_sclk_gen #(
    .SCLK_DIV(SCLK_DIV)
  ) u_sclk_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (sclk_en),
    .sclk    (sclk),
    .rise_stb(rise_stb),
    .fall_stb(fall_stb)
  );

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (cmd_vld)
          state_nxt = ST_JUDGE;
      ST_JUDGE:
        if (wait_cnt == LEAD_LAST)
          state_nxt = cmd_buf.wr ? ST_W_DATA : ST_R_ADDR;
      ST_W_DATA:
        if (fall_stb && bit_cnt == BW'(CMD_WIDTH - 1))
          state_nxt = ST_FINISH;
      ST_R_ADDR:
        if (fall_stb && bit_cnt == BW'(RD_ADDR_BITS - 1))
          state_nxt = ST_R_DATA;
      ST_R_DATA:
        if (fall_stb && bit_cnt == BW'(READ_WIDTH - 1))
          state_nxt = ST_FINISH;
      ST_FINISH:
        if (hold_over && (wr_flag || read_rdy))
          state_nxt = ST_GAP; // a stalled read waits here.
      ST_GAP:
        if (wait_cnt == HOLD_LAST)
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      wr_flag  <= 1'b0;
      bit_cnt  <= '0;
      wait_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (cmd_vld && cmd_rdy)
        wr_flag <= cmd_in.wr;
      if (state_nxt != state)
        bit_cnt <= '0;
      else if (fall_stb && sclk_en)
        bit_cnt <= bit_cnt + 1'b1;
      // one shared delay counter, restarted on every state change.
      if (state_nxt != state)
        wait_cnt <= '0;
      else if (wait_cnt != CNT_MAX)
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_buf <= cmd_in;
    else if (fall_stb && ((state == ST_W_DATA) || (state == ST_R_ADDR)))
      cmd_buf <= {cmd_buf[CMD_WIDTH-2:0], 1'b0};
    if (rise_stb && (state == ST_R_DATA))
      rx_shift <= {rx_shift[READ_WIDTH-2:0], miso};
  end

endmodule

`default_nettype wire

// File: verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // command word as written by the processor, MSB first on the wire.
  typedef struct packed {
    logic       wr;
    logic [2:0] addr;
    logic [7:0] data;
  } spi_cmd_t;

  typedef logic [7:0] spi_rd_t;

  localparam int CMD_WIDTH    = 12;
  localparam int READ_WIDTH   = 8;
  localparam int RD_ADDR_BITS = 4; // flag plus address.

  // apb byte offsets.
  localparam logic [3:0] REG_CMD    = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;
  localparam logic [3:0] REG_RXDATA = 4'h8;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_JUDGE,
    ST_W_DATA,
    ST_R_ADDR,
    ST_R_DATA,
    ST_FINISH,
    ST_GAP
  } spi_state_t;

endpackage

`default_nettype wire

// File: verilog/spi_sclk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module spi_sclk_gen #(
  parameter int SCLK_DIV = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  en,
  output logic sclk,
  output logic rise_stb,
  output logic fall_stb
);

  localparam int CW = $clog2(SCLK_DIV + 1);

  logic [CW-1:0] half_cnt;
  logic          half_done;

  assign half_done = (half_cnt == CW'(SCLK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end
    else if (!en)
    begin
      half_cnt <= '0; // back to idle low, ready for the next frame.
      sclk     <= 1'b0;
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end
    else if (half_done)
    begin
      half_cnt <= '0;
      sclk     <= ~sclk;
      rise_stb <= ~sclk; // strobes are high in the same cycle as the new level.
      fall_stb <= sclk;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module spi_sync_fifo #(
  parameter int FIFO_DEPTH = 4,
  parameter type payload_t = logic [7:0]
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       push_vld,
  input  payload_t  push_data,
  output logic      push_rdy,
  output logic      pop_vld,
  input  wire       pop_rdy,
  output payload_t  pop_data,
  output logic      full,
  output logic      not_empty
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  payload_t      mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign full      = (count == CW'(FIFO_DEPTH));
  assign not_empty = (count != '0);
  assign push_rdy  = ~full;
  assign pop_vld   = not_empty;
  assign pop_data  = mem[rd_ptr];
  assign do_push   = push_vld & push_rdy;
  assign do_pop    = pop_vld & pop_rdy;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // explicit wrap so a depth that is not a power of two still works.
      if (do_push)
        wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire
